//--- project.f
+incdir+source
source/video_pkg.sv
source/gfx_pkg.sv
source/pixel_clock_enable.sv
source/video_sync.sv
source/tile_pattern.sv
source/palette_ram.sv
source/video_top.sv
verif/video_props.sv
verif/video_tb.sv

//--- source/gfx_pkg.sv
`include "video_consts.svh"

package gfx_pkg;

    // palette index, used both for lookups and for host write addresses
    typedef logic [`PAL_IDX_W-1:0] pal_idx_t;

endpackage

//--- source/palette_ram.sv
`include "video_consts.svh"

module palette_ram
    import video_pkg::*;
    import gfx_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     en,
    input  pal_idx_t pal_idx,
    input  logic     lookup_valid,
    input  logic     pal_wr_valid,
    input  pal_idx_t pal_wr_addr,
    input  rgb_t     pal_wr_data,
    output rgb_t     pix,                            // one enable after pal_idx
    output logic     pal_wr_ready
);

    rgb_t mem [`PAL_DEPTH];
    logic rd_busy;                                   // pix holds a visible lookup

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_busy <= 1'b0;
        end else if (en) begin
            rd_busy <= lookup_valid;
        end
    end

    // host waits while any stage of a visible lookup is live
    assign pal_wr_ready = !lookup_valid && !rd_busy;

    always_ff @(posedge clk) begin
        if (pal_wr_valid && pal_wr_ready) begin
            mem[pal_wr_addr] <= pal_wr_data;
        end
        if (en) begin
            pix <= mem[pal_idx];                     // registered read
        end
    end

endmodule

//--- source/pixel_clock_enable.sv
module pixel_clock_enable #(
    parameter int MULTIPLIER = 1                    // clk cycles per en pulse, 1 or more
) (
    input  logic clk,
    input  logic arst_n,
    output logic en
);

    localparam int CW = (MULTIPLIER > 1) ? $clog2(MULTIPLIER) : 1;
    localparam logic [CW-1:0] LAST = CW'(MULTIPLIER - 1);

    logic [CW-1:0] cnt;                              // position inside the pixel period

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
            en  <= 1'b0;                             // quiet until first wrap
        end else begin
            en <= (cnt == LAST);                     // one pulse per wrap
            if (cnt == LAST) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + CW'(1);
            end
        end
    end

endmodule

//--- source/tile_pattern.sv
`include "video_consts.svh"

module tile_pattern
    import video_pkg::*;
    import gfx_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     en,
    input  x_index_t x_index,
    input  logic     x_index_valid,
    input  y_index_t y_index,
    input  logic     y_index_valid,
    output pal_idx_t pal_idx,                        // one enable after the index
    output logic     lookup_valid                    // pal_idx belongs to a visible pixel
);

    localparam int TW = 4;                           // tile coordinate width, bit 3 selects the 8px tile

    logic [TW-1:0] tx;
    logic [TW-1:0] ty;
    logic [2:0]    tile_idx;                         // raw checkerboard colour
    logic          idx_valid;

    // zero extend so the tile bit exists even for short axes
    assign tx = TW'(x_index);
    assign ty = TW'(y_index);

    assign idx_valid = x_index_valid && y_index_valid;

    always_comb begin
        tile_idx[2]   = tx[3] ^ ty[3];               // checkerboard parity
        tile_idx[1:0] = tx[2:1] ^ {2{ty[0]}};        // shade shifts every other row
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lookup_valid <= 1'b0;
        end else if (en) begin
            lookup_valid <= idx_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            pal_idx <= idx_valid ? pal_idx_t'(tile_idx) : '0;   // entry 0 outside the window
        end
    end

endmodule

//--- source/video_consts.svh
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// screen geometry in pixels and lines
`define VIS_W       16          // visible width
`define VIS_H       8           // visible height
`define TOT_W       24          // total width incl blanking
`define TOT_H       12          // total height incl blanking
`define HS_COL      4           // column where hs fires

`define PIX_PRE     2           // index lead, matches pattern + palette latency
`define PIX_MULT    2           // clk cycles per pixel enable
`define PAL_DEPTH   16          // palette entries

// derived widths
`define X_IDX_W     $clog2(`VIS_W)
`define Y_IDX_W     $clog2(`VIS_H)
`define ROW_W       $clog2(`TOT_H)
`define COL_W       $clog2(`TOT_W)
`define PAL_IDX_W   $clog2(`PAL_DEPTH)

`endif

//--- source/video_pkg.sv
`include "video_consts.svh"

package video_pkg;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    typedef struct packed {
        logic [2:0]  cmd;                          // command code
        logic [7:0]  frame;                        // frame counter for CMD_FRAME
        logic [12:0] rsvd;                         // kept zero
    } ctrl_word_t;

    // pixel while de is high, command while de is low
    typedef union packed {
        rgb_t       pix;
        ctrl_word_t ctrl;
    } vid_word_u;

    localparam logic [2:0] CMD_FRAME = 3'd1;        // start of frame marker

    typedef logic [`X_IDX_W-1:0] x_index_t;
    typedef logic [`Y_IDX_W-1:0] y_index_t;

endpackage

//--- source/video_sync.sv
`include "video_consts.svh"

module video_sync
    import video_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      en,                            // pixel enable
    input  rgb_t      rgb_in,                        // pixel from the palette, PIX_PRE behind index
    output logic      vs,                            // one clk, start of frame
    output logic      hs,                            // one clk, HS_COL into each line
    output logic      de,                            // visible pixel window
    output logic      skip,                          // de high without en
    output logic      line_start,                    // first pixel period of each line
    output x_index_t  x_index,
    output logic      x_index_valid,
    output y_index_t  y_index,
    output logic      y_index_valid,
    output vid_word_u vid                            // pixel or control word
);

    typedef logic [`ROW_W-1:0] row_t;
    typedef logic [`COL_W-1:0] col_t;

    localparam row_t VS_ROW     = row_t'(0);
    localparam col_t VS_COL     = col_t'(0);
    localparam col_t HS_C       = col_t'(`HS_COL);
    localparam row_t LAST_ROW   = row_t'(`TOT_H - 1);
    localparam col_t LAST_COL   = col_t'(`TOT_W - 1);

    // flags are registered, so they switch one enable before the target column/row
    localparam row_t DE_ROW_SET = row_t'(`TOT_H - `VIS_H - 1);
    localparam col_t DE_COL_SET = col_t'(`TOT_W - `VIS_W - 1);
    localparam col_t X_COL_SET  = col_t'(`TOT_W - `VIS_W - `PIX_PRE - 1);
    localparam col_t X_COL_CLR  = col_t'(`TOT_W - `PIX_PRE - 1);

    row_t       cur_row;
    col_t       cur_col;
    logic       de_row;
    logic       de_col;
    logic [7:0] frame_cnt;                           // frames since reset
    logic       last_col;
    logic       last_row;

    assign last_col = (cur_col == LAST_COL);
    assign last_row = (cur_row == LAST_ROW);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cur_row    <= '0;
            cur_col    <= '0;
            line_start <= 1'b0;
            frame_cnt  <= '0;
        end else if (en) begin
            line_start <= last_col;                  // held for the first pixel period
            if (last_col) begin
                cur_col <= '0;
                if (last_row) begin
                    cur_row   <= '0;
                    frame_cnt <= frame_cnt + 8'd1;   // wraps at 256
                end else begin
                    cur_row <= cur_row + row_t'(1);
                end
            end else begin
                cur_col <= cur_col + col_t'(1);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            de_row <= 1'b0;
            de_col <= 1'b0;
        end else if (en) begin
            if (cur_col == DE_COL_SET) begin
                de_col <= 1'b1;
            end else if (last_col) begin
                de_col <= 1'b0;
            end
            if (last_col && cur_row == DE_ROW_SET) begin
                de_row <= 1'b1;                      // next row is the first visible one
            end else if (last_col && last_row) begin
                de_row <= 1'b0;
            end
        end
    end

    // x index runs PIX_PRE pixels ahead of de to cover the lookup pipeline
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            x_index       <= '0;
            x_index_valid <= 1'b0;
        end else if (en) begin
            x_index <= x_index_valid ? x_index + x_index_t'(1) : '0;
            if (cur_col == X_COL_SET) begin
                x_index_valid <= 1'b1;
            end else if (cur_col == X_COL_CLR) begin
                x_index_valid <= 1'b0;
            end
        end
    end

    // y needs no lead, every lookup of a line lies inside that line
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            y_index       <= '0;
            y_index_valid <= 1'b0;
        end else if (en && last_col) begin
            y_index <= y_index_valid ? y_index + y_index_t'(1) : '0;
            if (cur_row == DE_ROW_SET) begin
                y_index_valid <= 1'b1;
            end else if (last_row) begin
                y_index_valid <= 1'b0;
            end
        end
    end

    always_comb begin
        vs   = (cur_row == VS_ROW) && (cur_col == VS_COL) && en;
        hs   = (cur_col == HS_C) && en;
        de   = de_row && de_col;
        skip = de && !en;
        vid  = '0;                                   // blanking default
        if (de) begin
            vid.pix = rgb_in;
        end else if (vs) begin
            vid.ctrl.cmd   = CMD_FRAME;              // frame marker rides on vs
            vid.ctrl.frame = frame_cnt;
        end
    end

endmodule

//--- source/video_top.sv
`include "video_consts.svh"

module video_top
    import video_pkg::*;
    import gfx_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      pal_wr_valid,                  // host palette write
    input  pal_idx_t  pal_wr_addr,
    input  rgb_t      pal_wr_data,
    output logic      pal_wr_ready,
    output logic      vs,
    output logic      hs,
    output logic      de,
    output logic      skip,
    output vid_word_u vid,
    output logic      line_start
);

    logic     en;
    x_index_t x_index;
    logic     x_index_valid;
    y_index_t y_index;
    logic     y_index_valid;
    pal_idx_t pal_idx;
    logic     lookup_valid;
    rgb_t     pix;                                   // palette colour back into the sync block

    pixel_clock_enable #(
        .MULTIPLIER(`PIX_MULT)
    ) i_pix_en (
        .clk    (clk),
        .arst_n (arst_n),
        .en     (en)
    );

    video_sync i_sync (
        .clk           (clk),
        .arst_n        (arst_n),
        .en            (en),
        .rgb_in        (pix),
        .vs            (vs),
        .hs            (hs),
        .de            (de),
        .skip          (skip),
        .line_start    (line_start),
        .x_index       (x_index),
        .x_index_valid (x_index_valid),
        .y_index       (y_index),
        .y_index_valid (y_index_valid),
        .vid           (vid)
    );

    tile_pattern i_pattern (
        .clk           (clk),
        .arst_n        (arst_n),
        .en            (en),
        .x_index       (x_index),
        .x_index_valid (x_index_valid),
        .y_index       (y_index),
        .y_index_valid (y_index_valid),
        .pal_idx       (pal_idx),
        .lookup_valid  (lookup_valid)
    );

    palette_ram i_palette (
        .clk          (clk),
        .arst_n       (arst_n),
        .en           (en),
        .pal_idx      (pal_idx),
        .lookup_valid (lookup_valid),
        .pal_wr_valid (pal_wr_valid),
        .pal_wr_addr  (pal_wr_addr),
        .pal_wr_data  (pal_wr_data),
        .pix          (pix),
        .pal_wr_ready (pal_wr_ready)
    );

endmodule

//--- verif/video_props.sv
`include "video_consts.svh"

module video_props
    import video_pkg::*;
(
    input logic              clk,
    input logic              arst_n,
    input logic              vs,
    input logic              hs,
    input logic              de,
    input logic [`ROW_W-1:0] row,                    // sync counters tied to zero where unused
    input logic [`COL_W-1:0] col,
    input logic              pal_wr_valid,
    input logic              pal_wr_ready,
    input rgb_t              pal_wr_data,
    input logic              lookup_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;                              // assertion failures so far

    task automatic count_failure(input string what);
        $error("%s", what);
        fail_count++;
    endtask

    // de may only rise at the first visible column of a visible row
    a_de_window: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(de) |-> col == (`TOT_W - `VIS_W) && row >= (`TOT_H - `VIS_H))
        else count_failure("de rose outside the visible window");

    a_vs_pulse: assert property (@(posedge clk) disable iff (!arst_n) vs |=> !vs)
        else count_failure("vs lasted longer than one clock");

    a_hs_pulse: assert property (@(posedge clk) disable iff (!arst_n) hs |=> !hs)
        else count_failure("hs lasted longer than one clock");

    // no write while a lookup or its palette read one pixel later is live
    a_wr_no_lookup: assert property (@(posedge clk) disable iff (!arst_n)
        pal_wr_valid && pal_wr_ready |-> !lookup_valid && !$past(lookup_valid, `PIX_MULT))
        else count_failure("palette write granted during a lookup");

    // host holds the request until it is taken
    a_wr_hold: assert property (@(posedge clk) disable iff (!arst_n)
        pal_wr_valid && !pal_wr_ready |=> pal_wr_valid && $stable(pal_wr_data))
        else count_failure("palette write request changed while stalled");

endmodule

bind video_sync video_props i_sync_props (
    .clk(clk), .arst_n(arst_n), .vs(vs), .hs(hs), .de(de), .row(cur_row), .col(cur_col),
    .pal_wr_valid(1'b0), .pal_wr_ready(1'b0), .pal_wr_data('0), .lookup_valid(1'b0)
);

bind palette_ram video_props i_pal_props (
    .clk(clk), .arst_n(arst_n), .vs(1'b0), .hs(1'b0), .de(1'b0), .row('0), .col('0),
    .pal_wr_valid(pal_wr_valid), .pal_wr_ready(pal_wr_ready), .pal_wr_data(pal_wr_data),
    .lookup_valid(lookup_valid)
);

//--- verif/video_tb.sv
`include "video_consts.svh"

module video_tb
    import video_pkg::*;
    import gfx_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int FRAME_EN    = `TOT_W * `TOT_H;     // enables per frame
    localparam int FRAME_CLK   = FRAME_EN * `PIX_MULT;
    localparam int TIMEOUT_CYC = FRAME_CLK * (4 + 3);  // four scanned frames plus three for reset and load

    logic      clk = 1'b0;
    logic      arst_n;
    logic      pal_wr_valid;
    pal_idx_t  pal_wr_addr;
    rgb_t      pal_wr_data;
    logic      pal_wr_ready;
    logic      vs;
    logic      hs;
    logic      de;
    logic      skip;
    logic      line_start;
    vid_word_u vid;

    rgb_t pal_model [`PAL_DEPTH];                    // colours written by the host
    int   seed   = 23588;
    int   cyc    = 0;                                // clk edges since reset release
    int   errors = 0;

    video_top i_dut (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        if (arst_n) begin
            cyc <= cyc + 1;
        end
        if (cyc >= TIMEOUT_CYC) begin
            $display("timeout: tests still running after %0d cycles", cyc);
            errors++;
            end_run();
        end
    end

    // en is high in the clk after every PIX_MULT-th edge past reset
    function automatic logic en_now();
        return cyc > 0 && cyc % `PIX_MULT == 0;
    endfunction

    function automatic ctrl_word_t frame_word(input logic [7:0] frame);
        ctrl_word_t w;
        w       = '0;
        w.cmd   = CMD_FRAME;
        w.frame = frame;
        return w;
    endfunction

    // checkerboard with tile parity on bit 3 and shade from x[2:1] flipped on odd rows
    function automatic pal_idx_t tile_index(input int x, input int y);
        return pal_idx_t'({x[3] ^ y[3], x[2:1] ^ {y[0], y[0]}});
    endfunction

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_ctrl(input string name, input ctrl_word_t exp, input ctrl_word_t act);
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            errors++;
            $display("[ERROR] %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic wait_vs();
        while (!vs) @(negedge clk);
    endtask

    task automatic reset_quiet_test();
        @(negedge clk);                              // first clk after release with en still low
        check_bit("vs", 1'b0, vs);
        check_bit("hs", 1'b0, hs);
        check_bit("de", 1'b0, de);
        check_bit("pal_wr_ready", 1'b1, pal_wr_ready);
        check_rgb("vid", '0, vid.pix);
        while (!en_now()) @(negedge clk);
        check_bit("vs", 1'b1, vs);                   // first enable opens frame 0
        check_ctrl("vid.ctrl", frame_word(8'd0), vid.ctrl);
    endtask

    task automatic palette_load_test();
        int stalls = 0;
        while (!de) @(negedge clk);                  // start inside a visible line
        for (int i = 0; i < `PAL_DEPTH; i++) begin
            pal_model[i] = 24'($random(seed));
            pal_wr_valid = 1'b1;
            pal_wr_addr  = pal_idx_t'(i);
            pal_wr_data  = pal_model[i];
            while (!pal_wr_ready) begin
                stalls++;
                @(negedge clk);
            end
            check_bit("de while pal_wr_ready", 1'b0, de);
            @(negedge clk);                          // transfer on the edge in between
        end
        pal_wr_valid = 1'b0;
        if (stalls == 0) begin
            errors++;
            $display("palette load never saw pal_wr_ready low");
        end
    endtask

    task automatic geometry_test();
        int n         = 0;
        int last_hs   = -1;
        int hs_pulses = 0;
        int lines     = 0;
        int vis_lines = 0;
        int skips     = 0;
        int de_per_line [`TOT_H] = '{default: 0};
        wait_vs();
        do begin
            check_bit("skip", de && !en_now(), skip);
            skips += skip;
            if (hs) begin
                hs_pulses++;
                if (last_hs >= 0) begin
                    check_count("clocks between hs", `PIX_MULT * `TOT_W, n - last_hs);
                end
                last_hs = n;
            end
            if (en_now() && line_start) begin
                lines++;
            end
            if (en_now() && de && lines > 0 && lines <= `TOT_H) begin
                de_per_line[lines - 1]++;
            end
            n++;
            @(negedge clk);
        end while (!vs);
        foreach (de_per_line[i]) begin
            if (de_per_line[i] != 0) begin
                check_count("de enables per line", `VIS_W, de_per_line[i]);
                vis_lines++;
            end
        end
        check_count("clocks per frame", FRAME_CLK, n);
        check_count("hs pulses per frame", `TOT_H, hs_pulses);
        check_count("line_start pulses per frame", `TOT_H, lines);
        check_count("visible lines", `VIS_H, vis_lines);
        check_count("skip clocks per frame", `VIS_W * `VIS_H * (`PIX_MULT - 1), skips);
    endtask

    task automatic pixel_test();
        int col = 0;
        int row = 0;
        wait_vs();
        do begin
            if (en_now() && de) begin
                check_rgb("vid.pix", pal_model[tile_index(col, row)], vid.pix);
                col++;
                if (col == `VIS_W) begin
                    col = 0;
                    row++;
                end
            end
            @(negedge clk);
        end while (!vs);
        check_count("rows with pixels", `VIS_H, row);
    endtask

    task automatic control_test(input int frames);
        int seen = 0;
        int k;
        wait_vs();
        do begin
            k = cyc / `PIX_MULT - 1;                 // enable number since reset
            check_bit("vs", en_now() && k % FRAME_EN == 0, vs);
            if (vs) begin
                seen++;
                check_ctrl("vid.ctrl", frame_word(8'(k / FRAME_EN)), vid.ctrl);
            end else if (en_now() && !de) begin
                check_ctrl("vid.ctrl", '0, vid.ctrl);    // plain blanking
            end
            @(negedge clk);
        end while (!(vs && seen == frames));
    endtask

    task automatic end_run();
        int asserts;
        asserts = i_dut.i_sync.i_sync_props.fail_count + i_dut.i_palette.i_pal_props.fail_count;
        $display("check errors: %0d, assertion failures: %0d", errors, asserts);
        if (errors + asserts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    initial begin
        arst_n       = 1'b0;
        pal_wr_valid = 1'b0;
        pal_wr_addr  = '0;
        pal_wr_data  = '0;
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
        reset_quiet_test();
        palette_load_test();
        geometry_test();
        pixel_test();
        control_test(2);
        end_run();
    end

endmodule
